// File: hw/axiuart_top.sv
`timescale 1ns/100ps
`default_nettype none

module axiuart_top #(
    parameter int                CLKS_PER_BIT  = 8,
    parameter int                FIFO_DEPTH    = 8,
    parameter int                HIGH_MARK     = 6,
    parameter regmap_pkg::addr_t REG_BASE_ADDR = 32'h0000_1000
) (
    input  wire  clk,
    input  wire  rst,
    input  wire  uart_rx,
    input  wire  uart_cts_n,
    output logic uart_tx,
    output logic uart_rts_n
);
    import link_pkg::*;
    import regmap_pkg::*;

    byte_t       rx_byte;
    byte_t       fifo_dout;
    byte_t       tx_byte;
    logic        rx_byte_valid;
    logic        fifo_pop, fifo_empty, fifo_full, fifo_high;
    logic        tx_start, tx_busy;
    addr_t       awaddr, araddr;
    data_t       wdata, rdata;
    resp_t       bresp, rresp;
    logic        awvalid, awready, wvalid, wready, bvalid, bready;
    logic        arvalid, arready, rvalid, rready;
    logic        stats_clear;
    status_t     last_status;
    logic [15:0] tx_count, rx_count;

    uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_rx (
        .clk, .rst, .rxd(uart_rx), .rx_byte, .rx_byte_valid
    );

    rx_fifo #(.FIFO_DEPTH(FIFO_DEPTH), .HIGH_MARK(HIGH_MARK)) u_fifo (
        .clk, .rst, .din(rx_byte), .push(rx_byte_valid), .pop(fifo_pop),
        .dout(fifo_dout), .empty(fifo_empty), .full(fifo_full), .high(fifo_high)
    );

    uart_axi_bridge #(.REG_BASE_ADDR(REG_BASE_ADDR)) u_bridge (
        .clk, .rst, .fifo_dout, .fifo_empty, .fifo_pop, .tx_byte, .tx_start, .tx_busy,
        .awaddr, .awvalid, .awready, .wdata, .wvalid, .wready, .bresp, .bvalid, .bready,
        .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
        .stats_clear, .last_status, .tx_count, .rx_count
    );

    register_block #(.REG_BASE_ADDR(REG_BASE_ADDR)) u_regs (
        .clk, .rst, .awaddr, .awvalid, .awready, .wdata, .wvalid, .wready,
        .bresp, .bvalid, .bready, .araddr, .arvalid, .arready, .rdata, .rresp,
        .rvalid, .rready, .stats_clear, .last_status, .tx_count, .rx_count
    );

    uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_tx (
        .clk, .rst, .tx_byte, .tx_start, .cts_n(uart_cts_n), .txd(uart_tx), .tx_busy
    );

    // RTS high stops the host while the FIFO is high or full
    always_ff @(posedge clk) begin
        if (rst) begin
            uart_rts_n <= 1'b1;
        end else begin
            uart_rts_n <= fifo_full || fifo_high;
        end
    end

endmodule

`default_nettype wire

// File: hw/link_pkg.sv
`default_nettype none

package link_pkg;

    typedef logic [7:0] byte_t;     // One serial byte on the line
    typedef logic [7:0] status_t;   // First byte of every response

    // Command byte of a frame
    localparam byte_t CMD_WRITE = 8'h01;   // Index plus four data bytes follow
    localparam byte_t CMD_READ  = 8'h02;   // Index byte follows

    // Response status codes
    localparam status_t ST_OK      = 8'h00;
    localparam status_t ST_BUS_ERR = 8'h01;   // Slave answered SLVERR
    localparam status_t ST_BAD_CMD = 8'h02;   // Unknown command byte

endpackage

`default_nettype wire

// File: hw/register_block.sv
`timescale 1ns/100ps
`default_nettype none

module register_block #(
    parameter regmap_pkg::addr_t REG_BASE_ADDR = 32'h0000_1000
) (
    input  wire                    clk,
    input  wire                    rst,
    input  wire regmap_pkg::addr_t awaddr,
    input  wire                    awvalid,
    output logic                   awready,
    input  wire regmap_pkg::data_t wdata,
    input  wire                    wvalid,
    output logic                   wready,
    output regmap_pkg::resp_t      bresp,
    output logic                   bvalid,
    input  wire                    bready,
    input  wire regmap_pkg::addr_t araddr,
    input  wire                    arvalid,
    output logic                   arready,
    output regmap_pkg::data_t      rdata,
    output regmap_pkg::resp_t      rresp,
    output logic                   rvalid,
    input  wire                    rready,
    output logic                   stats_clear,
    input  wire link_pkg::status_t last_status,
    input  wire [15:0]             tx_count,
    input  wire [15:0]             rx_count
);
    import regmap_pkg::*;

    data_t scratch;
    data_t rd_word;
    addr_t wr_off;     // Byte offset from base
    addr_t rd_off;
    logic  wr_hit;
    logic  rd_hit;
    logic  wr_en;
    logic  rd_en;

    assign wr_off = awaddr - REG_BASE_ADDR;
    assign rd_off = araddr - REG_BASE_ADDR;
    assign wr_hit = (wr_off < addr_t'(16)) && (wr_off[1:0] == 2'b00);   // Index 0 to 3
    assign rd_hit = (rd_off < addr_t'(16)) && (rd_off[1:0] == 2'b00);

    assign wr_en   = awvalid && wvalid && !bvalid;   // Both channels in one cycle
    assign awready = wr_en;
    assign wready  = wr_en;
    assign arready = !rvalid;
    assign rd_en   = arvalid && arready;

    always_comb begin
        rd_word = '0;   // Miss reads zero
        if (rd_hit) begin
            case (reg_idx_t'(rd_off[3:2]))
                REG_STATUS:  rd_word = data_t'(last_status);
                REG_COUNT:   rd_word = {tx_count, rx_count};
                REG_SCRATCH: rd_word = scratch;
                default:     rd_word = '0;   // Control reads back zero
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            bvalid      <= 1'b0;
            stats_clear <= 1'b0;
            scratch     <= '0;
        end else begin
            stats_clear <= 1'b0;
            if (bvalid && bready) begin
                bvalid <= 1'b0;
            end
            if (wr_en) begin
                bvalid <= 1'b1;
                bresp  <= wr_hit ? RESP_OKAY : RESP_SLVERR;
                if (wr_hit && wr_off[3:2] == REG_SCRATCH) begin
                    scratch <= wdata;
                end
                if (wr_hit && wr_off[3:2] == REG_CONTROL && wdata[0]) begin
                    stats_clear <= 1'b1;   // One-cycle pulse
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rvalid <= 1'b0;
        end else begin
            if (rvalid && rready) begin
                rvalid <= 1'b0;
            end
            if (rd_en) begin
                rvalid <= 1'b1;
                rresp  <= rd_hit ? RESP_OKAY : RESP_SLVERR;
                rdata  <= rd_word;
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/regmap_pkg.sv
`default_nettype none

package regmap_pkg;

    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;

    typedef logic [ADDR_W-1:0] addr_t;   // Byte address
    typedef logic [DATA_W-1:0] data_t;   // Full bus word
    typedef logic [1:0]        resp_t;   // AXI BRESP / RRESP
    typedef logic [1:0]        reg_idx_t;

    localparam resp_t RESP_OKAY   = 2'b00;
    localparam resp_t RESP_SLVERR = 2'b10;

    // Word index inside the register block
    localparam reg_idx_t REG_CONTROL = 2'd0;   // Bit 0 clears the link counters
    localparam reg_idx_t REG_STATUS  = 2'd1;   // Last response status
    localparam reg_idx_t REG_COUNT   = 2'd2;   // tx count high, rx count low
    localparam reg_idx_t REG_SCRATCH = 2'd3;

endpackage

`default_nettype wire

// File: hw/rx_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module rx_fifo #(
    parameter int FIFO_DEPTH = 8,
    parameter int HIGH_MARK  = 6
) (
    input  wire                  clk,
    input  wire                  rst,
    input  wire link_pkg::byte_t din,
    input  wire                  push,
    input  wire                  pop,
    output link_pkg::byte_t      dout,
    output logic                 empty,
    output logic                 full,
    output logic                 high
);
    import link_pkg::*;

    localparam int AW = $clog2(FIFO_DEPTH);

    byte_t         mem [FIFO_DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   level;        // 0 to FIFO_DEPTH
    logic [AW:0]   level_next;
    logic          do_push;
    logic          do_pop;

    assign do_push    = push && !full;    // Push on full is lost
    assign do_pop     = pop && !empty;
    assign level_next = level + (AW + 1)'(do_push) - (AW + 1)'(do_pop);

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level  <= '0;
            empty  <= 1'b1;
            full   <= 1'b0;
            high   <= 1'b0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == AW'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == AW'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            level <= level_next;
            empty <= (level_next == '0);   // Flags lag the access by a cycle
            full  <= (level_next == (AW + 1)'(FIFO_DEPTH));
            high  <= (level_next >= (AW + 1)'(HIGH_MARK));
        end
    end

    assign dout = mem[rd_ptr];   // Fall-through head

endmodule

`default_nettype wire

// File: hw/uart_axi_bridge.sv
`timescale 1ns/100ps
`default_nettype none

module uart_axi_bridge #(
    parameter regmap_pkg::addr_t REG_BASE_ADDR = 32'h0000_1000
) (
    input  wire                    clk,
    input  wire                    rst,
    input  wire link_pkg::byte_t   fifo_dout,
    input  wire                    fifo_empty,
    output logic                   fifo_pop,
    output link_pkg::byte_t        tx_byte,
    output logic                   tx_start,
    input  wire                    tx_busy,
    output regmap_pkg::addr_t      awaddr,
    output logic                   awvalid,
    input  wire                    awready,
    output regmap_pkg::data_t      wdata,
    output logic                   wvalid,
    input  wire                    wready,
    input  wire regmap_pkg::resp_t bresp,
    input  wire                    bvalid,
    output logic                   bready,
    output regmap_pkg::addr_t      araddr,
    output logic                   arvalid,
    input  wire                    arready,
    input  wire regmap_pkg::data_t rdata,
    input  wire regmap_pkg::resp_t rresp,
    input  wire                    rvalid,
    output logic                   rready,
    input  wire                    stats_clear,
    output link_pkg::status_t      last_status,
    output logic [15:0]            tx_count,
    output logic [15:0]            rx_count
);
    import link_pkg::*;
    import regmap_pkg::*;

    typedef enum logic [2:0] {CMD, INDEX, DATA, BUS_WR, BUS_RD, RESP} state_t;

    state_t     state;
    byte_t      cmd;
    addr_t      bus_addr;
    data_t      rd_word;      // Read data, sent LSB first
    status_t    status;
    logic [2:0] cnt;          // Write data bytes, later response bytes
    logic [2:0] resp_len;     // 1 or 5
    logic       frame_done;
    logic       resp_done;

    function automatic status_t to_status(resp_t r);
        return (r == RESP_OKAY) ? ST_OK : ST_BUS_ERR;
    endfunction

    assign fifo_pop = (state == CMD || state == INDEX || state == DATA) && !fifo_empty;
    assign tx_start = (state == RESP) && !tx_busy;
    assign tx_byte  = (cnt == 3'd0) ? status : rd_word[7:0];
    assign awaddr   = bus_addr;
    assign araddr   = bus_addr;
    assign bready   = (state == BUS_WR);
    assign rready   = (state == BUS_RD);

    // Last byte of a frame leaves the FIFO
    assign frame_done = fifo_pop &&
        ((state == CMD && fifo_dout != CMD_WRITE && fifo_dout != CMD_READ) ||
         (state == INDEX && cmd == CMD_READ) ||
         (state == DATA && cnt == 3'd3));
    assign resp_done = tx_start && (cnt == resp_len - 1'b1);

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= CMD;
            cnt     <= '0;
            awvalid <= 1'b0;
            wvalid  <= 1'b0;
            arvalid <= 1'b0;
        end else begin
            case (state)
                CMD: if (fifo_pop) begin
                    cmd <= fifo_dout;
                    if (fifo_dout == CMD_WRITE || fifo_dout == CMD_READ) begin
                        state <= INDEX;
                    end else begin
                        status   <= ST_BAD_CMD;   // One-byte frame, no bus access
                        resp_len <= 3'd1;
                        cnt      <= '0;
                        state    <= RESP;
                    end
                end
                INDEX: if (fifo_pop) begin
                    bus_addr <= REG_BASE_ADDR + addr_t'({fifo_dout, 2'b00});
                    cnt      <= '0;
                    if (cmd == CMD_READ) begin
                        arvalid <= 1'b1;
                        state   <= BUS_RD;
                    end else begin
                        state <= DATA;
                    end
                end
                DATA: if (fifo_pop) begin
                    wdata <= {fifo_dout, wdata[31:8]};   // LSB arrives first
                    cnt   <= cnt + 1'b1;
                    if (cnt == 3'd3) begin
                        awvalid <= 1'b1;   // Address and data together
                        wvalid  <= 1'b1;
                        state   <= BUS_WR;
                    end
                end
                BUS_WR: begin
                    if (awready) awvalid <= 1'b0;
                    if (wready) wvalid <= 1'b0;
                    if (bvalid) begin
                        status   <= to_status(bresp);
                        resp_len <= 3'd1;
                        cnt      <= '0;
                        state    <= RESP;
                    end
                end
                BUS_RD: begin
                    if (arready) arvalid <= 1'b0;
                    if (rvalid) begin
                        status   <= to_status(rresp);
                        rd_word  <= rdata;   // Zero on SLVERR
                        resp_len <= 3'd5;
                        cnt      <= '0;
                        state    <= RESP;
                    end
                end
                RESP: if (tx_start) begin
                    cnt <= cnt + 1'b1;
                    if (cnt != 3'd0) begin
                        rd_word <= rd_word >> 8;   // Next data byte
                    end
                    if (resp_done) begin
                        state <= CMD;
                    end
                end
                default: state <= CMD;
            endcase
        end
    end

    // Link counters, cleared from REG_CONTROL
    always_ff @(posedge clk) begin
        if (rst || stats_clear) begin
            rx_count <= '0;
            tx_count <= '0;
        end else begin
            if (frame_done) rx_count <= rx_count + 1'b1;   // Before the bus access
            if (resp_done) tx_count <= tx_count + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            last_status <= ST_OK;
        end else if (resp_done) begin
            last_status <= status;   // Same cycle as tx_count
        end
    end

endmodule

`default_nettype wire

// File: hw/uart_rx.sv
`timescale 1ns/100ps
`default_nettype none

module uart_rx #(
    parameter int CLKS_PER_BIT = 8
) (
    input  wire             clk,
    input  wire             rst,
    input  wire             rxd,
    output link_pkg::byte_t rx_byte,
    output logic            rx_byte_valid
);
    import link_pkg::*;

    localparam int CW = $clog2(CLKS_PER_BIT + 1);

    typedef enum logic [1:0] {IDLE, START, DATA, STOP} state_t;

    state_t        state;
    logic          rxd_meta;   // Synchronizer stage 1
    logic          rxd_s;      // Synchronized line
    logic [CW-1:0] clk_cnt;
    logic [2:0]    bit_idx;
    byte_t         shreg;

    always_ff @(posedge clk) begin
        if (rst) begin
            rxd_meta <= 1'b1;   // Line idles high
            rxd_s    <= 1'b1;
        end else begin
            rxd_meta <= rxd;
            rxd_s    <= rxd_meta;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state         <= IDLE;
            clk_cnt       <= '0;
            bit_idx       <= '0;
            rx_byte_valid <= 1'b0;
        end else begin
            rx_byte_valid <= 1'b0;
            clk_cnt       <= clk_cnt + 1'b1;
            case (state)
                IDLE: begin
                    clk_cnt <= '0;
                    if (!rxd_s) begin
                        state <= START;   // Start bit edge
                    end
                end
                START: if (clk_cnt == CW'(CLKS_PER_BIT / 2 - 1)) begin
                    clk_cnt <= '0;        // Now at mid start bit
                    bit_idx <= '0;
                    state   <= rxd_s ? IDLE : DATA;   // Short glitch, no frame
                end
                DATA: if (clk_cnt == CW'(CLKS_PER_BIT - 1)) begin
                    clk_cnt <= '0;
                    shreg   <= {rxd_s, shreg[7:1]};   // LSB first
                    bit_idx <= bit_idx + 1'b1;
                    if (bit_idx == 3'd7) begin
                        state <= STOP;
                    end
                end
                STOP: if (clk_cnt == CW'(CLKS_PER_BIT - 1)) begin
                    rx_byte_valid <= rxd_s;   // Bad stop bit drops the byte
                    state         <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    assign rx_byte = shreg;

endmodule

`default_nettype wire

// File: hw/uart_tx.sv
`timescale 1ns/100ps
`default_nettype none

module uart_tx #(
    parameter int CLKS_PER_BIT = 8
) (
    input  wire                  clk,
    input  wire                  rst,
    input  wire link_pkg::byte_t tx_byte,
    input  wire                  tx_start,
    input  wire                  cts_n,
    output logic                 txd,
    output logic                 tx_busy
);
    import link_pkg::*;

    localparam int CW = $clog2(CLKS_PER_BIT + 1);

    typedef enum logic [2:0] {IDLE, WAIT_CTS, START, DATA, STOP} state_t;

    state_t        state;
    logic [CW-1:0] clk_cnt;
    logic [2:0]    bit_idx;
    byte_t         shreg;
    logic          cts_meta;
    logic          cts_s;
    logic          bit_done;

    assign bit_done = (clk_cnt == CW'(CLKS_PER_BIT - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= IDLE;
            clk_cnt  <= '0;
            bit_idx  <= '0;
            cts_meta <= 1'b1;   // Host not ready until seen low
            cts_s    <= 1'b1;
        end else begin
            cts_meta <= cts_n;
            cts_s    <= cts_meta;
            clk_cnt  <= bit_done ? '0 : clk_cnt + 1'b1;
            case (state)
                IDLE: if (tx_start) begin
                    shreg <= tx_byte;
                    state <= WAIT_CTS;
                end
                WAIT_CTS: begin
                    clk_cnt <= '0;   // Bit timing starts with the start bit
                    if (!cts_s) begin
                        state <= START;
                    end
                end
                START: if (bit_done) begin
                    bit_idx <= '0;
                    state   <= DATA;
                end
                DATA: if (bit_done) begin
                    shreg   <= shreg >> 1;
                    bit_idx <= bit_idx + 1'b1;
                    if (bit_idx == 3'd7) begin
                        state <= STOP;
                    end
                end
                STOP: if (bit_done) state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    assign txd     = (state == START) ? 1'b0 : (state == DATA) ? shreg[0] : 1'b1;
    assign tx_busy = (state != IDLE);   // Includes the CTS wait

endmodule

`default_nettype wire

// File: tb.f
hw/link_pkg.sv
hw/regmap_pkg.sv
hw/uart_rx.sv
hw/uart_tx.sv
hw/rx_fifo.sv
hw/uart_axi_bridge.sv
hw/register_block.sv
hw/axiuart_top.sv
testbench/uart_host.sv
testbench/tb_axiuart.sv

// File: testbench/tb_axiuart.sv
`timescale 1ns/100ps
`default_nettype none

module tb_axiuart;
    import link_pkg::*;
    import regmap_pkg::*;

    localparam int    CLKS_PER_BIT  = 8;
    localparam int    FIFO_DEPTH    = 8;
    localparam int    HIGH_MARK     = 6;
    localparam addr_t REG_BASE_ADDR = 32'h0000_1000;
    localparam int    FLOW_FRAMES   = 5;
    // Scratch 4 x 8, errors 11, counters 10, flow 5 x 2
    localparam int    FRAME_BYTES   = 32 + 11 + 10 + 2 * FLOW_FRAMES;
    localparam int    TIMEOUT_CYCLES = FRAME_BYTES * 10 * CLKS_PER_BIT * 2
                                       + 50 * 10 * CLKS_PER_BIT;

    logic clk;
    logic rst;
    wire  uart_rx;
    wire  uart_cts_n;
    wire  uart_tx;
    wire  uart_rts_n;

    // Reference model state
    data_t       scratch_m = '0;
    logic [15:0] rx_m      = '0;
    logic [15:0] tx_m      = '0;
    status_t     last_m    = ST_OK;

    // Expected responses, oldest first
    status_t exp_status_q[$];
    data_t   exp_data_q[$];
    bit      exp_read_q[$];
    string   exp_name_q[$];

    int     frame_count = 0;
    int     resp_count  = 0;
    int     cycle_count = 0;
    bit     checker_on  = 1'b0;
    integer seed        = 32'h16ec_20d0;

    axiuart_top #(
        .CLKS_PER_BIT(CLKS_PER_BIT),
        .FIFO_DEPTH(FIFO_DEPTH),
        .HIGH_MARK(HIGH_MARK),
        .REG_BASE_ADDR(REG_BASE_ADDR)
    ) dut (
        .clk, .rst, .uart_rx, .uart_cts_n, .uart_tx, .uart_rts_n
    );

    uart_host #(.CLKS_PER_BIT(CLKS_PER_BIT)) host (
        .clk, .rxd(uart_tx), .rts_n(uart_rts_n), .txd(uart_rx), .cts_n(uart_cts_n)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic check_status(input string name, input status_t exp, input status_t act);
        if (act !== exp) begin
            abort_run($sformatf("ERR %s expected %02h actual %02h", name, exp, act));
        end
    endtask

    task automatic check_data(input string name, input data_t exp, input data_t act);
        if (act !== exp) begin
            abort_run($sformatf("ERR %s expected %08h actual %08h", name, exp, act));
        end
    endtask

    task automatic check_line(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            abort_run($sformatf("ERR %s expected %b actual %b", name, exp, act));
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp) begin
            abort_run($sformatf("ERR %s expected %0d actual %0d", name, exp, act));
        end
    endtask

    // Predicts status and read word of one frame and steps the model
    function automatic void predict_response(input byte_t cmd, input byte_t idx,
                                             input data_t wr, output status_t st,
                                             output data_t rd, output bit is_rd);
        st    = ST_OK;
        rd    = '0;
        is_rd = (cmd == CMD_READ);
        rx_m  = rx_m + 16'd1;   // Counted before the bus access
        if (cmd != CMD_WRITE && cmd != CMD_READ) begin
            st = ST_BAD_CMD;
        end else if (idx > 8'd3) begin
            st = ST_BUS_ERR;    // No register there so the read word stays zero
        end else if (is_rd) begin
            case (reg_idx_t'(idx[1:0]))
                REG_STATUS:  rd = {24'd0, last_m};
                REG_COUNT:   rd = {tx_m, rx_m};
                REG_SCRATCH: rd = scratch_m;
                default:     rd = '0;
            endcase
        end else if (reg_idx_t'(idx[1:0]) == REG_SCRATCH) begin
            scratch_m = wr;
        end else if (reg_idx_t'(idx[1:0]) == REG_CONTROL && wr[0]) begin
            rx_m = '0;          // Clear lands after this frame was counted
            tx_m = '0;
        end
        tx_m   = tx_m + 16'd1;  // This response
        last_m = st;
    endfunction

    task automatic send_frame(input byte_t cmd, input byte_t idx, input data_t wr,
                              input string name);
        status_t st;
        data_t   rd;
        bit      is_rd;
        int      k;
        predict_response(cmd, idx, wr, st, rd, is_rd);
        exp_status_q.push_back(st);
        exp_data_q.push_back(rd);
        exp_read_q.push_back(is_rd);
        exp_name_q.push_back(name);
        frame_count++;
        host.send_byte(cmd);
        if (cmd == CMD_WRITE || cmd == CMD_READ) begin
            host.send_byte(idx);
        end
        if (cmd == CMD_WRITE) begin
            for (k = 0; k < 4; k++) begin
                host.send_byte(wr[8*k +: 8]);   // LSB first
            end
        end
    endtask

    task automatic wait_responses();
        while (resp_count != frame_count) @(negedge clk);
    endtask

    // Response checker
    initial begin
        byte_t   b;
        bit      ok;
        data_t   word;
        bit      is_rd;
        string   name;
        int      k;
        wait (checker_on);
        forever begin
            host.recv_byte(b, ok);
            if (!ok) begin
                abort_run("Response byte from the DUT has a bad start or stop bit");
            end
            if (exp_status_q.size() == 0) begin
                abort_run("Response byte arrived with no frame outstanding");
            end
            name  = exp_name_q.pop_front();
            is_rd = exp_read_q.pop_front();
            check_status(name, exp_status_q.pop_front(), status_t'(b));
            word = '0;
            if (is_rd) begin
                for (k = 0; k < 4; k++) begin
                    host.recv_byte(b, ok);
                    if (!ok) begin
                        abort_run("Read data byte from the DUT has a bad start or stop bit");
                    end
                    word[8*k +: 8] = b;
                end
                check_data(name, exp_data_q.pop_front(), word);
            end else begin
                void'(exp_data_q.pop_front());
            end
            resp_count++;
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            abort_run($sformatf("Timeout: the run did not finish in %0d cycles",
                                TIMEOUT_CYCLES));
        end
    end

    initial begin
        data_t word;
        int    i;
        rst = 1'b1;
        repeat (3) @(negedge clk);   // Three reset cycles
        check_line("reset tx idle", 1'b1, uart_tx);
        check_line("reset rts", 1'b1, uart_rts_n);
        rst = 1'b0;
        @(negedge clk);
        check_line("rts after reset", 1'b0, uart_rts_n);
        checker_on = 1'b1;

        // Scratch write then read back
        for (i = 0; i < 4; i++) begin
            word = $random(seed);
            send_frame(CMD_WRITE, byte_t'(REG_SCRATCH), word, "scratch write");
            send_frame(CMD_READ, byte_t'(REG_SCRATCH), '0, "scratch read");
        end
        wait_responses();

        // Error paths
        send_frame(CMD_READ, 8'd9, '0, "bus error read");
        send_frame(CMD_WRITE, 8'd9, 32'hdead_beef, "bus error write");
        send_frame(8'h55, 8'd0, '0, "bad command");
        send_frame(CMD_READ, byte_t'(REG_STATUS), '0, "status read");
        wait_responses();

        // Link counters and their clear
        send_frame(CMD_READ, byte_t'(REG_COUNT), '0, "count read");
        send_frame(CMD_WRITE, byte_t'(REG_CONTROL), 32'h1, "counter clear");
        send_frame(CMD_READ, byte_t'(REG_COUNT), '0, "count after clear");
        wait_responses();

        // Flow control with responses held back by CTS
        host.set_cts(1'b1);
        host.arm_pause_watch();
        fork
            begin
                for (i = 0; i < FLOW_FRAMES; i++) begin
                    send_frame(CMD_READ, byte_t'(REG_SCRATCH), '0, "flow read");
                end
            end
            begin
                while (host.pause_at < 0) begin
                    @(negedge clk);
                    check_line("flow tx held", 1'b1, uart_tx);
                end
                // First frame drains to the bridge and the FIFO then fills to the mark
                check_count("flow pause point", 2 + HIGH_MARK, host.pause_at);
                host.set_cts(1'b0);
            end
        join
        wait_responses();

        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire

// File: testbench/uart_host.sv
`timescale 1ns/100ps
`default_nettype none

module uart_host #(
    parameter int CLKS_PER_BIT = 8
) (
    input  wire  clk,
    input  wire  rxd,     // From the DUT transmitter
    input  wire  rts_n,   // High asks the host to hold off
    output logic txd,     // To the DUT receiver
    output logic cts_n    // High holds back the DUT transmitter
);
    import link_pkg::*;

    int sent_count;   // Bytes sent since the last arm
    int pause_at;     // Byte count at the first RTS wait, -1 if none

    initial begin
        txd        = 1'b1;   // Idle line
        cts_n      = 1'b0;
        sent_count = 0;
        pause_at   = -1;
    end

    task automatic arm_pause_watch();
        sent_count = 0;
        pause_at   = -1;
    endtask

    task automatic set_cts(input logic level);
        @(negedge clk);
        cts_n = level;
    endtask

    // One byte, LSB first, then stop bit and one idle bit
    task automatic send_byte(input byte_t b);
        int i;
        @(negedge clk);
        if (rts_n && pause_at < 0) begin
            pause_at = sent_count;
        end
        while (rts_n) @(negedge clk);   // Flow control from the DUT
        txd = 1'b0;
        repeat (CLKS_PER_BIT) @(negedge clk);
        for (i = 0; i < 8; i++) begin
            txd = b[i];
            repeat (CLKS_PER_BIT) @(negedge clk);
        end
        txd = 1'b1;
        repeat (2 * CLKS_PER_BIT) @(negedge clk);
        sent_count++;
    endtask

    // Samples each bit in its middle on the falling clock edge
    task automatic recv_byte(output byte_t b, output bit framing_ok);
        int i;
        b = '0;
        wait (rxd === 1'b0);                      // Start bit edge
        repeat (CLKS_PER_BIT / 2) @(negedge clk);
        framing_ok = (rxd === 1'b0);              // Still inside the start bit
        for (i = 0; i < 8; i++) begin
            repeat (CLKS_PER_BIT) @(negedge clk);
            b[i] = rxd;
        end
        repeat (CLKS_PER_BIT) @(negedge clk);
        framing_ok = framing_ok && (rxd === 1'b1);   // Stop bit
    endtask

endmodule

`default_nettype wire
